//--- hw/snn_consts.svh
// spiking layer controller constants
// word and address widths, bank depth and the layer descriptor table
`ifndef SNN_CONSTS_SVH
`define SNN_CONSTS_SVH

// 8 pixels by 4 time steps per word
`define SNN_SPIKE_W   32
`define SNN_ADDR_W    10
`define SNN_RAM_DEPTH 1024
`define SNN_FIELD_W   16
`define SNN_LAYER_NUM 2

`define SNN_L0_IN_CH  16'd2
`define SNN_L0_OUT_CH 16'd2
`define SNN_L0_IMG    16'd4
`define SNN_L0_THRD   16'd12
`define SNN_L0_BIAS   16'd3

// in_ch of layer 1 follows out_ch of layer 0
`define SNN_L1_IN_CH  16'd2
`define SNN_L1_OUT_CH 16'd1
`define SNN_L1_IMG    16'd4
`define SNN_L1_THRD   16'd9
`define SNN_L1_BIAS   16'd2

`endif

//--- hw/snn_pkg.sv
// spiking layer controller types
// vector typedefs for words, addresses and descriptor fields,
// plus the layer sequencer state encoding
`default_nettype none

`include "snn_consts.svh"

package snn_pkg;

    typedef logic [`SNN_SPIKE_W-1:0] spike_word_t;
    typedef logic [`SNN_ADDR_W-1:0]  ram_addr_t;
    typedef logic [`SNN_FIELD_W-1:0] code_field_t;
    typedef logic [0:0]              layer_idx_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        SWITCH,
        SEND,
        COLLECT,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire

//--- hw/layer_code_rom.sv
// layer descriptor table
// answers each code request with a single valid pulse carrying the
// fields of the current layer, then steps to the next layer
`timescale 1ns/1ns
`default_nettype none

`include "snn_consts.svh"

module layer_code_rom (
    input  wire logic                s_clk,
    input  wire logic                s_rst,
    input  wire logic                i_code_req,
    output logic                     o_code_valid,
    output snn_pkg::code_field_t     o_in_ch,
    output snn_pkg::code_field_t     o_out_ch,
    output snn_pkg::code_field_t     o_img_size,
    output snn_pkg::code_field_t     o_lif_thrd,
    output snn_pkg::code_field_t     o_bias_scale,
    output logic                     o_last
);
    import snn_pkg::*;

    layer_idx_t layer_idx;

    // one pulse per request, the held request is not answered twice
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_code_valid <= 1'b0;
            layer_idx    <= '0;
        end else begin
            o_code_valid <= i_code_req && !o_code_valid;
            if (o_code_valid) begin
                if (o_last)
                    layer_idx <= '0;
                else
                    layer_idx <= layer_idx + 1'b1;
            end
        end
    end

    assign o_last = (layer_idx == layer_idx_t'(`SNN_LAYER_NUM - 1));

    always_comb begin
        if (layer_idx == '0) begin
            o_in_ch      = `SNN_L0_IN_CH;
            o_out_ch     = `SNN_L0_OUT_CH;
            o_img_size   = `SNN_L0_IMG;
            o_lif_thrd   = `SNN_L0_THRD;
            o_bias_scale = `SNN_L0_BIAS;
        end else begin
            o_in_ch      = `SNN_L1_IN_CH;
            o_out_ch     = `SNN_L1_OUT_CH;
            o_img_size   = `SNN_L1_IMG;
            o_lif_thrd   = `SNN_L1_THRD;
            o_bias_scale = `SNN_L1_BIAS;
        end
    end

endmodule

`default_nettype wire

//--- hw/layer_sequencer.sv
// layer sequencer
// orders code fetch, bank swap, ifmap send and result collect for
// every layer, and holds the done level until the part is released
`timescale 1ns/1ns
`default_nettype none

module layer_sequencer (
    input  wire logic s_clk,
    input  wire logic s_rst,
    input  wire logic i_encoder_done,
    input  wire logic i_part_done,
    input  wire logic i_code_valid,
    input  wire logic i_code_last,
    input  wire logic i_ifmap_done,
    input  wire logic i_array_done,
    output logic      o_code_req,
    output logic      o_bank_swap,
    output logic      o_send_en,
    output logic      o_collect_en,
    output logic      o_layers_done,
    output logic      o_busy
);
    import snn_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;
    logic       last_layer;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // remember whether the fetched code closes the run
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            last_layer <= 1'b0;
        else if (state == FETCH && i_code_valid)
            last_layer <= i_code_last;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (i_encoder_done) state_nxt = FETCH;
            FETCH:   if (i_code_valid) state_nxt = SWITCH;
            SWITCH:  state_nxt = SEND;
            SEND:    if (i_ifmap_done) state_nxt = COLLECT;
            COLLECT: begin
                if (i_array_done)
                    state_nxt = last_layer ? DONE : FETCH;
            end
            DONE:    if (i_part_done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign o_code_req    = (state == FETCH);
    assign o_bank_swap   = (state == SWITCH);
    assign o_send_en     = (state == SEND);
    assign o_collect_en  = (state == COLLECT);
    assign o_layers_done = (state == DONE);
    assign o_busy        = (state != IDLE);

    // the reader ends its stream only inside the send phase
    a_ifmap_done_in_send: assert property (
        @(posedge s_clk) disable iff (s_rst)
        i_ifmap_done |-> o_send_en);

endmodule

`default_nettype wire

//--- hw/ifmap_reader.sv
// ifmap reader
// raster walk over every padded channel plane, border positions
// send a zero word, interior positions read the spike RAM
`timescale 1ns/1ns
`default_nettype none

module ifmap_reader (
    input  wire logic                 s_clk,
    input  wire logic                 s_rst,
    input  wire logic                 i_send_en,
    input  wire snn_pkg::code_field_t i_in_ch,
    input  wire snn_pkg::code_field_t i_img_size,
    input  wire logic                 i_ifmap_ready,
    output snn_pkg::ram_addr_t        o_rd_addr,
    input  wire snn_pkg::spike_word_t i_rd_data,
    output logic                      o_ifmap_valid,
    output logic                      o_ifmap_done,
    output snn_pkg::spike_word_t      o_ifmap_spikes
);
    import snn_pkg::*;

    code_field_t ch;
    code_field_t row;
    code_field_t col;
    code_field_t pad_last;
    ram_addr_t   rd_ptr;
    logic        send_d;
    logic        start;
    logic        active;
    logic        rd_pend;
    logic        border;
    logic        border_q;
    logic        at_last;
    logic        last_q;
    logic        issue;
    logic        accept;

    assign pad_last = i_img_size + 16'd1;
    assign start    = i_send_en && !send_d;
    assign accept   = o_ifmap_valid && i_ifmap_ready;
    // one beat in flight, next read goes out as the slot frees
    assign issue    = active && !rd_pend && (!o_ifmap_valid || accept);
    assign border   = (row == '0) || (row == pad_last) || (col == '0) || (col == pad_last);
    assign at_last  = (ch == i_in_ch - 16'd1) && (row == pad_last) && (col == pad_last);

    // interior pixels come up in linear address order
    assign o_rd_addr = rd_ptr;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            send_d <= 1'b0;
            active <= 1'b0;
            ch     <= '0;
            row    <= '0;
            col    <= '0;
            rd_ptr <= '0;
        end else begin
            send_d <= i_send_en;
            if (start) begin
                active <= 1'b1;
                ch     <= '0;
                row    <= '0;
                col    <= '0;
                rd_ptr <= '0;
            end else if (issue) begin
                if (!border)
                    rd_ptr <= rd_ptr + 1'b1;
                if (at_last)
                    active <= 1'b0;
                if (col == pad_last) begin
                    col <= '0;
                    if (row == pad_last) begin
                        row <= '0;
                        ch  <= ch + 16'd1;
                    end else begin
                        row <= row + 16'd1;
                    end
                end else begin
                    col <= col + 16'd1;
                end
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            rd_pend       <= 1'b0;
            o_ifmap_valid <= 1'b0;
            o_ifmap_done  <= 1'b0;
            last_q        <= 1'b0;
        end else begin
            rd_pend      <= issue;
            o_ifmap_done <= accept && last_q;
            if (rd_pend)
                o_ifmap_valid <= 1'b1;
            else if (accept)
                o_ifmap_valid <= 1'b0;
            if (issue)
                last_q <= at_last;
            else if (accept)
                last_q <= 1'b0;
        end
    end

    always_ff @(posedge s_clk) begin
        if (issue)
            border_q <= border;
        if (rd_pend)
            o_ifmap_spikes <= border_q ? '0 : i_rd_data;
    end

    a_hold_on_stall: assert property (
        @(posedge s_clk) disable iff (s_rst)
        o_ifmap_valid && !i_ifmap_ready |=> o_ifmap_valid && $stable(o_ifmap_spikes));

endmodule

`default_nettype wire

//--- hw/ofmap_writer.sv
// ofmap writer
// takes result beats from the array while collecting and turns
// them into sequential RAM write requests one cycle later
`timescale 1ns/1ns
`default_nettype none

`include "snn_consts.svh"

module ofmap_writer (
    input  wire logic                 s_clk,
    input  wire logic                 s_rst,
    input  wire logic                 i_collect_en,
    input  wire logic                 i_array_valid,
    input  wire snn_pkg::spike_word_t i_array_spikes,
    output logic                      o_array_ready,
    output logic                      o_wr_en,
    output snn_pkg::ram_addr_t        o_wr_addr,
    output snn_pkg::spike_word_t      o_wr_data
);
    import snn_pkg::*;

    // one extra bit so a wrap past the bank end is visible
    logic [`SNN_ADDR_W:0] wr_cnt;
    logic [`SNN_ADDR_W:0] wr_base;
    logic                 collect_d;
    logic                 collect_rise;
    logic                 accept;

    assign o_array_ready = i_collect_en;
    assign accept        = i_collect_en && i_array_valid;
    assign collect_rise  = i_collect_en && !collect_d;
    assign wr_base       = collect_rise ? '0 : wr_cnt;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            collect_d <= 1'b0;
            o_wr_en   <= 1'b0;
            wr_cnt    <= '0;
        end else begin
            collect_d <= i_collect_en;
            o_wr_en   <= accept;
            if (accept)
                wr_cnt <= wr_base + 1'b1;
            else if (collect_rise)
                wr_cnt <= '0;
        end
    end

    always_ff @(posedge s_clk) begin
        if (accept) begin
            o_wr_addr <= wr_base[`SNN_ADDR_W-1:0];
            o_wr_data <= i_array_spikes;
        end
    end

    a_addr_in_bank: assert property (
        @(posedge s_clk) disable iff (s_rst)
        accept |-> wr_base < `SNN_RAM_DEPTH);

endmodule

`default_nettype wire

//--- hw/pingpong_spike_ram.sv
// ping-pong spike RAM
// two banks behind a select register, reads go to the read bank,
// writer and load port share the write port of the other bank
`timescale 1ns/1ns
`default_nettype none

`include "snn_consts.svh"

module pingpong_spike_ram (
    input  wire logic                 s_clk,
    input  wire logic                 s_rst,
    input  wire logic                 i_bank_swap,
    input  wire logic                 i_load_we,
    input  wire snn_pkg::ram_addr_t   i_load_addr,
    input  wire snn_pkg::spike_word_t i_load_data,
    input  wire snn_pkg::ram_addr_t   i_rd_addr,
    output snn_pkg::spike_word_t      o_rd_data,
    input  wire logic                 i_wr_en,
    input  wire snn_pkg::ram_addr_t   i_wr_addr,
    input  wire snn_pkg::spike_word_t i_wr_data
);
    import snn_pkg::*;

    spike_word_t bank0 [0:`SNN_RAM_DEPTH-1];
    spike_word_t bank1 [0:`SNN_RAM_DEPTH-1];
    logic        bank_sel;
    logic        wr_bank;
    logic        wr_we;
    ram_addr_t   wr_addr;
    spike_word_t wr_data;

    // sel 0 reads bank 0, sel 1 reads bank 1
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            bank_sel <= 1'b0;
        else if (i_bank_swap)
            bank_sel <= ~bank_sel;
    end

    // load fills the bank the next layer will read after its swap
    assign wr_bank = ~bank_sel;
    assign wr_we   = i_wr_en || i_load_we;
    assign wr_addr = i_wr_en ? i_wr_addr : i_load_addr;
    assign wr_data = i_wr_en ? i_wr_data : i_load_data;

    always_ff @(posedge s_clk) begin
        if (wr_we && !wr_bank)
            bank0[wr_addr] <= wr_data;
    end

    always_ff @(posedge s_clk) begin
        if (wr_we && wr_bank)
            bank1[wr_addr] <= wr_data;
    end

    always_ff @(posedge s_clk) begin
        o_rd_data <= bank_sel ? bank1[i_rd_addr] : bank0[i_rd_addr];
    end

    a_one_writer: assert property (
        @(posedge s_clk) disable iff (s_rst)
        !(i_load_we && i_wr_en));

endmodule

`default_nettype wire

//--- hw/snn_layer_ctrl.sv
// spiking convolution layer controller
// fetches layer codes, streams padded ifmaps to the array, stores
// its results in the ping-pong spike RAM and swaps banks per layer
`timescale 1ns/1ns
`default_nettype none

module snn_layer_ctrl (
    input  wire logic                 s_clk,
    input  wire logic                 s_rst,
    input  wire logic                 i_encoder_done,
    input  wire logic                 i_part_done,
    input  wire logic                 i_load_we,
    input  wire snn_pkg::ram_addr_t   i_load_addr,
    input  wire snn_pkg::spike_word_t i_load_data,
    input  wire logic                 i_ifmap_ready,
    output logic                      o_ifmap_valid,
    output snn_pkg::spike_word_t      o_ifmap_spikes,
    output logic                      o_ifmap_done,
    input  wire logic                 i_array_valid,
    input  wire snn_pkg::spike_word_t i_array_spikes,
    input  wire logic                 i_array_done,
    output logic                      o_array_ready,
    output logic                      o_code_valid,
    output snn_pkg::code_field_t      o_conv_in_ch,
    output snn_pkg::code_field_t      o_conv_out_ch,
    output snn_pkg::code_field_t      o_conv_img_size,
    output snn_pkg::code_field_t      o_conv_lif_thrd,
    output snn_pkg::code_field_t      o_conv_bias_scale,
    output logic                      o_layers_done,
    output logic                      o_busy
);
    import snn_pkg::*;

    logic        code_req;
    logic        rom_valid;
    logic        rom_last;
    code_field_t rom_in_ch;
    code_field_t rom_out_ch;
    code_field_t rom_img_size;
    code_field_t rom_lif_thrd;
    code_field_t rom_bias_scale;
    logic        bank_swap;
    logic        send_en;
    logic        collect_en;
    ram_addr_t   rd_addr;
    spike_word_t rd_data;
    logic        wr_en;
    ram_addr_t   wr_addr;
    spike_word_t wr_data;

    // code fields stay valid for the whole layer
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_code_valid      <= 1'b0;
            o_conv_in_ch      <= '0;
            o_conv_out_ch     <= '0;
            o_conv_img_size   <= '0;
            o_conv_lif_thrd   <= '0;
            o_conv_bias_scale <= '0;
        end else begin
            o_code_valid <= rom_valid;
            if (rom_valid) begin
                o_conv_in_ch      <= rom_in_ch;
                o_conv_out_ch     <= rom_out_ch;
                o_conv_img_size   <= rom_img_size;
                o_conv_lif_thrd   <= rom_lif_thrd;
                o_conv_bias_scale <= rom_bias_scale;
            end
        end
    end

    layer_code_rom u_code_rom (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_code_req   (code_req),
        .o_code_valid (rom_valid),
        .o_in_ch      (rom_in_ch),
        .o_out_ch     (rom_out_ch),
        .o_img_size   (rom_img_size),
        .o_lif_thrd   (rom_lif_thrd),
        .o_bias_scale (rom_bias_scale),
        .o_last       (rom_last)
    );

    layer_sequencer u_sequencer (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_encoder_done (i_encoder_done),
        .i_part_done    (i_part_done),
        .i_code_valid   (rom_valid),
        .i_code_last    (rom_last),
        .i_ifmap_done   (o_ifmap_done),
        .i_array_done   (i_array_done),
        .o_code_req     (code_req),
        .o_bank_swap    (bank_swap),
        .o_send_en      (send_en),
        .o_collect_en   (collect_en),
        .o_layers_done  (o_layers_done),
        .o_busy         (o_busy)
    );

    ifmap_reader u_reader (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_send_en      (send_en),
        .i_in_ch        (o_conv_in_ch),
        .i_img_size     (o_conv_img_size),
        .i_ifmap_ready  (i_ifmap_ready),
        .o_rd_addr      (rd_addr),
        .i_rd_data      (rd_data),
        .o_ifmap_valid  (o_ifmap_valid),
        .o_ifmap_done   (o_ifmap_done),
        .o_ifmap_spikes (o_ifmap_spikes)
    );

    ofmap_writer u_writer (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_collect_en   (collect_en),
        .i_array_valid  (i_array_valid),
        .i_array_spikes (i_array_spikes),
        .o_array_ready  (o_array_ready),
        .o_wr_en        (wr_en),
        .o_wr_addr      (wr_addr),
        .o_wr_data      (wr_data)
    );

    pingpong_spike_ram u_spike_ram (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_bank_swap (bank_swap),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_rd_addr   (rd_addr),
        .o_rd_data   (rd_data),
        .i_wr_en     (wr_en),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data)
    );

endmodule

`default_nettype wire

//--- test/tb_snn_layer_ctrl.sv
// testbench for the spiking layer controller
// loads the first ifmaps, models the processing array and both RAM
// banks, and checks the padded beat stream, codes and done level
`timescale 1ns/1ns
`default_nettype none

`include "snn_consts.svh"

module tb_snn_layer_ctrl;
    import snn_pkg::*;

    typedef struct packed {
        logic [15:0] in_ch;
        logic [15:0] out_ch;
        logic [15:0] img_size;
        logic [15:0] lif_thrd;
        logic [15:0] bias_scale;
        logic [15:0] results;
        logic [15:0] stall_pct;
    } layer_row_t;

    localparam int LAYERS     = 2;
    localparam int LOAD_WORDS = `SNN_L0_IN_CH * `SNN_L0_IMG * `SNN_L0_IMG;
    localparam int SEND_BEATS = `SNN_L0_IN_CH * (`SNN_L0_IMG + 2) * (`SNN_L0_IMG + 2)
                              + `SNN_L1_IN_CH * (`SNN_L1_IMG + 2) * (`SNN_L1_IMG + 2);
    localparam int RES_BEATS  = `SNN_L0_OUT_CH * `SNN_L0_IMG * `SNN_L0_IMG
                              + `SNN_L1_OUT_CH * `SNN_L1_IMG * `SNN_L1_IMG;
    localparam int CYCLE_LIMIT = 20 * (LOAD_WORDS + SEND_BEATS + RES_BEATS);

    logic        s_clk;
    logic        s_rst;
    logic        i_encoder_done;
    logic        i_part_done;
    logic        i_load_we;
    ram_addr_t   i_load_addr;
    spike_word_t i_load_data;
    logic        i_ifmap_ready;
    logic        o_ifmap_valid;
    spike_word_t o_ifmap_spikes;
    logic        o_ifmap_done;
    logic        i_array_valid;
    spike_word_t i_array_spikes;
    logic        i_array_done;
    logic        o_array_ready;
    logic        o_code_valid;
    code_field_t o_conv_in_ch;
    code_field_t o_conv_out_ch;
    code_field_t o_conv_img_size;
    code_field_t o_conv_lif_thrd;
    code_field_t o_conv_bias_scale;
    logic        o_layers_done;
    logic        o_busy;

    layer_row_t  layer_table [0:LAYERS-1];
    logic [31:0] model_mem [0:1][0:63];
    logic        model_sel;
    logic [31:0] rng;
    int          error_count;
    int          cycle_count = 0;

    snn_layer_ctrl snn_layer_ctrl_i (
        .s_clk             (s_clk),
        .s_rst             (s_rst),
        .i_encoder_done    (i_encoder_done),
        .i_part_done       (i_part_done),
        .i_load_we         (i_load_we),
        .i_load_addr       (i_load_addr),
        .i_load_data       (i_load_data),
        .i_ifmap_ready     (i_ifmap_ready),
        .o_ifmap_valid     (o_ifmap_valid),
        .o_ifmap_spikes    (o_ifmap_spikes),
        .o_ifmap_done      (o_ifmap_done),
        .i_array_valid     (i_array_valid),
        .i_array_spikes    (i_array_spikes),
        .i_array_done      (i_array_done),
        .o_array_ready     (o_array_ready),
        .o_code_valid      (o_code_valid),
        .o_conv_in_ch      (o_conv_in_ch),
        .o_conv_out_ch     (o_conv_out_ch),
        .o_conv_img_size   (o_conv_img_size),
        .o_conv_lif_thrd   (o_conv_lif_thrd),
        .o_conv_bias_scale (o_conv_bias_scale),
        .o_layers_done     (o_layers_done),
        .o_busy            (o_busy)
    );

    initial begin
        s_clk = 1'b0;
        forever #50 s_clk = ~s_clk;
    end

    always @(posedge s_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // padded raster position to the word the array should see
    function automatic logic [31:0] expected_beat(input int idx, input int n);
        int pad;
        int c;
        int rem;
        int pr;
        int pc;
        pad = n + 2;
        c   = idx / (pad * pad);
        rem = idx % (pad * pad);
        pr  = rem / pad;
        pc  = rem % pad;
        if (pr == 0 || pr == pad - 1 || pc == 0 || pc == pad - 1)
            return '0;
        return model_mem[model_sel][c * n * n + (pr - 1) * n + (pc - 1)];
    endfunction

    task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // wait for the next drive point after a rising edge
    task tick;
        @(posedge s_clk);
        #10;
    endtask

    task run_layer(input int li);
        layer_row_t row;
        int         n;
        int         beats;
        int         idx;
        int         k;
        row   = layer_table[li];
        n     = int'(row.img_size);
        beats = int'(row.in_ch) * (n + 2) * (n + 2);
        // bank swap in the model, last written bank becomes the read bank
        model_sel = ~model_sel;

        while (!o_code_valid)
            tick;
        check_value("o_conv_in_ch", 32'(o_conv_in_ch), 32'(row.in_ch));
        check_value("o_conv_out_ch", 32'(o_conv_out_ch), 32'(row.out_ch));
        check_value("o_conv_img_size", 32'(o_conv_img_size), 32'(row.img_size));
        check_value("o_conv_lif_thrd", 32'(o_conv_lif_thrd), 32'(row.lif_thrd));
        check_value("o_conv_bias_scale", 32'(o_conv_bias_scale), 32'(row.bias_scale));
        tick;
        check_value("o_code_valid", 32'(o_code_valid), 32'd0);

        idx = 0;
        while (idx < beats) begin
            rng = lcg_step(rng);
            i_ifmap_ready = (rng[31:16] % 16'd100) >= row.stall_pct;
            check_value("o_ifmap_done", 32'(o_ifmap_done), 32'd0);
            check_value("o_code_valid", 32'(o_code_valid), 32'd0);
            if (o_ifmap_valid && i_ifmap_ready) begin
                check_value("o_ifmap_spikes", o_ifmap_spikes, expected_beat(idx, n));
                idx = idx + 1;
            end
            tick;
        end
        i_ifmap_ready = 1'b0;
        check_value("o_ifmap_done", 32'(o_ifmap_done), 32'd1);
        tick;
        check_value("o_ifmap_done", 32'(o_ifmap_done), 32'd0);
        check_value("o_ifmap_valid", 32'(o_ifmap_valid), 32'd0);

        // array results go to the other bank
        while (!o_array_ready)
            tick;
        k = 0;
        while (k < int'(row.results)) begin
            check_value("o_array_ready", 32'(o_array_ready), 32'd1);
            rng = lcg_step(rng);
            if ((rng[31:16] % 16'd100) >= row.stall_pct) begin
                rng = lcg_step(rng);
                i_array_valid  = 1'b1;
                i_array_spikes = rng;
                model_mem[~model_sel][k] = rng;
                k = k + 1;
            end else begin
                i_array_valid = 1'b0;
            end
            tick;
        end
        i_array_valid = 1'b0;
        i_array_done  = 1'b1;
        tick;
        i_array_done = 1'b0;
        check_value("o_layers_done", 32'(o_layers_done), (li == LAYERS - 1) ? 32'd1 : 32'd0);
    endtask

    initial begin
        s_rst          = 1'b1;
        i_encoder_done = 1'b0;
        i_part_done    = 1'b0;
        i_load_we      = 1'b0;
        i_load_addr    = '0;
        i_load_data    = '0;
        i_ifmap_ready  = 1'b0;
        i_array_valid  = 1'b0;
        i_array_spikes = '0;
        i_array_done   = 1'b0;
        rng            = 32'hdea70ff1;
        error_count    = 0;
        model_sel      = 1'b0;

        // expected code, result beats, ready stall percent
        layer_table[0] = {16'd2, 16'd2, 16'd4, `SNN_L0_THRD, `SNN_L0_BIAS, 16'd32, 16'd35};
        layer_table[1] = {16'd2, 16'd1, 16'd4, `SNN_L1_THRD, `SNN_L1_BIAS, 16'd16, 16'd50};

        repeat (2) @(posedge s_clk);
        #10;
        s_rst = 1'b0;
        tick;
        check_value("o_ifmap_valid", 32'(o_ifmap_valid), 32'd0);
        check_value("o_ifmap_done", 32'(o_ifmap_done), 32'd0);
        check_value("o_array_ready", 32'(o_array_ready), 32'd0);
        check_value("o_code_valid", 32'(o_code_valid), 32'd0);
        check_value("o_layers_done", 32'(o_layers_done), 32'd0);
        check_value("o_busy", 32'(o_busy), 32'd0);

        // layer 0 ifmaps land in the bank not selected at reset
        for (int a = 0; a < LOAD_WORDS; a++) begin
            rng = lcg_step(rng);
            i_load_we   = 1'b1;
            i_load_addr = ram_addr_t'(a);
            i_load_data = rng;
            model_mem[1][a] = rng;
            tick;
        end
        i_load_we = 1'b0;

        i_encoder_done = 1'b1;
        tick;
        i_encoder_done = 1'b0;

        for (int li = 0; li < LAYERS; li++)
            run_layer(li);

        repeat (4) begin
            check_value("o_layers_done", 32'(o_layers_done), 32'd1);
            tick;
        end
        i_part_done = 1'b1;
        tick;
        i_part_done = 1'b0;
        check_value("o_layers_done", 32'(o_layers_done), 32'd0);
        check_value("o_busy", 32'(o_busy), 32'd0);

        if (error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hw
hw/snn_pkg.sv
hw/layer_code_rom.sv
hw/layer_sequencer.sv
hw/ifmap_reader.sv
hw/ofmap_writer.sv
hw/pingpong_spike_ram.sv
hw/snn_layer_ctrl.sv
test/tb_snn_layer_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the layer controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f flist.f --top-module tb_snn_layer_ctrl \
    -Mdir obj_dir -o sim_tb

sim_out=$(./obj_dir/sim_tb 2>&1) || true
echo "$sim_out"

if grep -q "All tests passed" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
